//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_sysbus
FILELIST  = verilog.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir

//--- logic/bus_master.sv
`timescale 1ns/1ps

`include "sysbus_defs.svh"

module bus_master (
	input  logic clk_sys,
	input  logic rst_n,
	// request port
	input  sysbus_pkg::bus_req_t req,
	input  logic req_valid,
	output logic req_ready,
	// response port
	output sysbus_pkg::bus_rsp_t rsp,
	output logic rsp_valid,
	input  logic rsp_ready,
	// reservation
	output logic zg,
	input  logic zw,
	// bus
	output sysbus_pkg::sysbus_t drv,
	input  sysbus_pkg::sysbus_t bus_rcv
);

	localparam int TMO_W = $clog2(`BUS_TIMEOUT + 1);

	typedef enum logic [1:0] {
		S_IDLE,
		S_RESERVE,
		S_XFER,
		S_RESPOND
	} state_e;

	state_e state;
	logic armed_q;                     // first clear has been seen
	logic [TMO_W-1:0] tmo_cnt;
	sysbus_pkg::bus_req_t req_q;
	sysbus_pkg::bus_rsp_t rsp_q;

	// ------------------------------
	// port handshakes
	// ------------------------------

	// no requests before the first clear or while clear is up
	assign req_ready = (state == S_IDLE) && armed_q && !bus_rcv.cl;
	assign rsp_valid = (state == S_RESPOND);
	assign rsp = rsp_q;

	// ------------------------------
	// control FSM
	// ------------------------------

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state   <= S_IDLE;
			armed_q <= 1'b0;
			tmo_cnt <= '0;
		end else begin
			armed_q <= armed_q | bus_rcv.cl;
			if (bus_rcv.cl) begin
				// abort, no response for the dropped transfer
				state <= S_IDLE;
			end else begin
				case (state)
					S_IDLE: if (req_valid && req_ready) state <= S_RESERVE;
					// wait for grant and for the last ok to go away
					S_RESERVE: if (zw && !bus_rcv.ok) begin
						state   <= S_XFER;
						tmo_cnt <= '0;
					end
					S_XFER: if (bus_rcv.ok) begin
						state <= S_RESPOND;
					end else if (tmo_cnt == TMO_W'(`BUS_TIMEOUT - 1)) begin
						// silent bus, report missing memory
						state <= S_RESPOND;
					end else begin
						tmo_cnt <= tmo_cnt + 1'b1;
					end
					S_RESPOND: if (rsp_ready) state <= S_IDLE;
					default: state <= S_IDLE;
				endcase
			end
		end
	end

	// ------------------------------
	// payload
	// ------------------------------

	always_ff @(posedge clk_sys) begin
		if (state == S_IDLE && req_valid && req_ready) req_q <= req;
		if (state == S_XFER) begin
			if (bus_rcv.ok) begin
				// writes return zero data
				rsp_q.dt     <= req_q.write ? 16'h0000 : bus_rcv.dt;
				rsp_q.status <= sysbus_pkg::RSP_OK;
			end else begin
				rsp_q.dt     <= 16'h0000;
				rsp_q.status <= sysbus_pkg::RSP_NOMEM;
			end
		end
	end

	// reservation held until the transfer ends
	assign zg = (state == S_RESERVE) || (state == S_XFER);

	// drive the bus only while transferring, zeros otherwise
	always_comb begin
		drv = '0;
		if (state == S_XFER) begin
			drv.w  = req_q.write;
			drv.r  = !req_q.write;
			drv.nb = req_q.nb;
			drv.ad = req_q.ad;
			drv.dt = req_q.write ? req_q.dt : 16'h0000;
		end
	end

endmodule

//--- logic/bus_memory.sv
`timescale 1ns/1ps

`include "sysbus_defs.svh"

module bus_memory (
	input  logic clk_sys,
	input  logic rst_n,
	input  sysbus_pkg::sysbus_t bus_rcv,
	output sysbus_pkg::sysbus_t drv
);

	localparam int DEPTH = 1 << `MEM_ADDR_BITS;

	logic [15:0] mem [0:DEPTH-1];
	logic [`MEM_ADDR_BITS-1:0] word_addr;
	logic hit;
	logic req_on;
	logic ok_q;
	logic rd_q;                        // answering a read
	logic [15:0] rd_data;

	// ------------------------------
	// address decode
	// ------------------------------

	assign word_addr = bus_rcv.ad[`MEM_ADDR_BITS-1:0];

	// block 0 and below the memory size only
	assign hit = (bus_rcv.nb == 4'd0) && (bus_rcv.ad[15:`MEM_ADDR_BITS] == '0);

	// request for us, ignored while the bus is cleared
	assign req_on = (bus_rcv.r || bus_rcv.w) && hit && !bus_rcv.cl;

	// ------------------------------
	// four-phase answer
	// ------------------------------

	// ok follows r/w by one cycle, both on the way up and down
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			ok_q <= 1'b0;
			rd_q <= 1'b0;
		end else begin
			ok_q <= req_on;
			rd_q <= req_on && bus_rcv.r;
		end
	end

	// store once, on the edge where ok rises
	always_ff @(posedge clk_sys) begin
		if (req_on && bus_rcv.w && !ok_q) mem[word_addr] <= bus_rcv.dt;
	end

	// read data captured with ok, held for the whole answer
	always_ff @(posedge clk_sys) begin
		if (req_on && bus_rcv.r && !ok_q) rd_data <= mem[word_addr];
	end

	// only ok and read data, the rest stays low
	always_comb begin
		drv    = '0;
		drv.ok = ok_q;
		drv.dt = rd_q ? rd_data : 16'h0000;
	end

endmodule

//--- logic/bus_switch.sv
`timescale 1ns/1ps

module bus_switch (
	input  logic clk_sys,
	input  logic rst_n,
	// unit drivers
	input  sysbus_pkg::sysbus_t cpu_drv,
	input  sysbus_pkg::sysbus_t io_drv,
	input  sysbus_pkg::sysbus_t mem_drv,
	input  sysbus_pkg::sysbus_t clr_drv,
	// reservation, bit 0 is the cpu port
	input  logic [1:0] zg,
	output logic [1:0] zw,
	// receiver view shared by all units
	output sysbus_pkg::sysbus_t bus_rcv
);

	// current owner, one-hot or zero
	logic [1:0] grant_q;
	logic owner_holds;

	// ------------------------------
	// wired bus
	// ------------------------------

	// open collector emulation
	// idle units drive zeros, so a plain OR gives the wired result
	assign bus_rcv = cpu_drv | io_drv | mem_drv | clr_drv;

	// ------------------------------
	// reservation
	// ------------------------------

	// owner still asking for the bus
	assign owner_holds = |(grant_q & zg);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			grant_q <= 2'b00;
		end else if (bus_rcv.cl) begin
			// clear drops any reservation
			grant_q <= 2'b00;
		end else if (!owner_holds) begin
			// free or released, cpu port wins ties
			if (zg[0]) begin
				grant_q <= 2'b01;
			end else if (zg[1]) begin
				grant_q <= 2'b10;
			end else begin
				grant_q <= 2'b00;
			end
		end
	end

	// grant only shows while the owner keeps zg up
	// drops in the same cycle as zg
	assign zw = grant_q & zg;

endmodule

//--- logic/power_clear.sv
`timescale 1ns/1ps

`include "sysbus_defs.svh"

module power_clear (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic clear_req,
	output sysbus_pkg::sysbus_t drv
);

	localparam int CNT_W = $clog2(`CLEAR_CYCLES + 1);

	logic pending_q;                   // clear still owed after reset
	logic [CNT_W-1:0] cnt;

	// ------------------------------
	// clear stretcher
	// ------------------------------

	// reset release or operator request loads the count
	// a request during a clear starts it over
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			pending_q <= 1'b1;
			cnt       <= '0;
		end else begin
			pending_q <= 1'b0;
			if (pending_q || clear_req) begin
				cnt <= CNT_W'(`CLEAR_CYCLES);
			end else if (cnt != '0) begin
				cnt <= cnt - 1'b1;
			end
		end
	end

	// cl only, nothing else on the bus
	always_comb begin
		drv    = '0;
		drv.cl = (cnt != '0);
	end

endmodule

//--- logic/sysbus_defs.svh
`ifndef SYSBUS_DEFS_SVH
`define SYSBUS_DEFS_SVH

// ------------------------------
// system bus sizing
// ------------------------------

// word address bits of the internal memory
// block 0 only, so addresses 0..255
`define MEM_ADDR_BITS 8

// cycles a master waits for ok before giving up
`define BUS_TIMEOUT 16

// length of the bus clear in cycles
`define CLEAR_CYCLES 8

`endif

//--- logic/sysbus_pkg.sv
package sysbus_pkg;

	// ------------------------------
	// bus lines of one unit
	// ------------------------------

	// each unit drives one of these, the switch ORs them together
	typedef struct packed {
		logic w;           // write request
		logic r;           // read request
		logic cl;          // bus clear
		logic ok;          // acknowledge
		logic [3:0] nb;    // memory block
		logic [15:0] ad;   // word address
		logic [15:0] dt;   // data
	} sysbus_t;

	// ------------------------------
	// port side transfers
	// ------------------------------

	// request word taken on the valid/ready port
	typedef struct packed {
		logic write;
		logic [3:0] nb;
		logic [15:0] ad;
		logic [15:0] dt;
	} bus_req_t;

	// nomem when nobody answered within the timeout
	typedef enum logic [0:0] {
		RSP_OK    = 1'b0,
		RSP_NOMEM = 1'b1
	} rsp_status_e;

	// read data, or zero on writes and nomem
	typedef struct packed {
		logic [15:0] dt;
		rsp_status_e status;
	} bus_rsp_t;

endpackage

//--- logic/sysbus_top.sv
`timescale 1ns/1ps

module sysbus_top (
	input  logic clk_sys,
	input  logic rst_n,
	input  logic clear_req,
	// cpu port
	input  sysbus_pkg::bus_req_t cpu_req,
	input  logic cpu_req_valid,
	output logic cpu_req_ready,
	output sysbus_pkg::bus_rsp_t cpu_rsp,
	output logic cpu_rsp_valid,
	input  logic cpu_rsp_ready,
	// i/o port
	input  sysbus_pkg::bus_req_t io_req,
	input  logic io_req_valid,
	output logic io_req_ready,
	output sysbus_pkg::bus_rsp_t io_rsp,
	output logic io_rsp_valid,
	input  logic io_rsp_ready
);

	// ------------------------------
	// bus wiring
	// ------------------------------

	// one driver per unit, one shared receiver view
	sysbus_pkg::sysbus_t cpu_drv, io_drv, mem_drv, clr_drv;
	sysbus_pkg::sysbus_t bus_rcv;

	// reservation, bit 0 cpu, bit 1 i/o
	logic [1:0] zg;
	logic [1:0] zw;

	bus_switch u_switch (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.cpu_drv(cpu_drv), .io_drv(io_drv), .mem_drv(mem_drv), .clr_drv(clr_drv),
		.zg(zg), .zw(zw), .bus_rcv(bus_rcv)
	);

	// ------------------------------
	// bus masters
	// ------------------------------

	bus_master u_cpu_master (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.req(cpu_req), .req_valid(cpu_req_valid), .req_ready(cpu_req_ready),
		.rsp(cpu_rsp), .rsp_valid(cpu_rsp_valid), .rsp_ready(cpu_rsp_ready),
		.zg(zg[0]), .zw(zw[0]), .drv(cpu_drv), .bus_rcv(bus_rcv)
	);

	bus_master u_io_master (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.req(io_req), .req_valid(io_req_valid), .req_ready(io_req_ready),
		.rsp(io_rsp), .rsp_valid(io_rsp_valid), .rsp_ready(io_rsp_ready),
		.zg(zg[1]), .zw(zw[1]), .drv(io_drv), .bus_rcv(bus_rcv)
	);

	// ------------------------------
	// memory and power/clear
	// ------------------------------

	bus_memory u_memory (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.bus_rcv(bus_rcv), .drv(mem_drv)
	);

	power_clear u_power_clear (
		.clk_sys(clk_sys), .rst_n(rst_n),
		.clear_req(clear_req), .drv(clr_drv)
	);

endmodule

//--- verif/sysbus_properties.sv
`timescale 1ns/1ps

module sysbus_properties (
	input logic clk_sys,
	input logic rst_n,
	input logic [1:0] zg,
	input logic [1:0] zw,
	input sysbus_pkg::sysbus_t bus_rcv
);

	// ------------------------------
	// reservation
	// ------------------------------

	// one owner at most
	a_grant_onehot: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$onehot0(zw)) else $error("zw not one-hot: %b", zw);

	// grant only follows a request already up the cycle before
	a_grant_needs_req: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(zw & ~$past(zg)) == 2'b00) else $error("zw %b without earlier zg", zw);

	// owner keeps its grant as long as it holds zg
	a_grant_stable_cpu: assert property (@(posedge clk_sys) disable iff (!rst_n)
		zw[0] |=> (!zg[0] || zw[0])) else $error("cpu grant lost while zg held");
	a_grant_stable_io: assert property (@(posedge clk_sys) disable iff (!rst_n)
		zw[1] |=> (!zg[1] || zw[1])) else $error("i/o grant lost while zg held");

	// ------------------------------
	// four-phase rule
	// ------------------------------

	// ok only answers an r or w seen one cycle earlier
	a_ok_after_req: assert property (@(posedge clk_sys) disable iff (!rst_n)
		bus_rcv.ok |-> $past(bus_rcv.r || bus_rcv.w)) else $error("ok without r or w");

endmodule

bind sysbus_top sysbus_properties u_properties (
	.clk_sys(clk_sys), .rst_n(rst_n), .zg(zg), .zw(zw), .bus_rcv(bus_rcv)
);

//--- verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk
);

	// 4 ns period, so toggle every 2 ns
	initial clk = 1'b0;

	always #2 clk = ~clk;

endmodule

//--- verif/tb_sysbus.sv
`timescale 1ns/1ps

`include "sysbus_defs.svh"

module tb_sysbus;

	localparam int WAIT_LIMIT = 100;
	localparam int MEM_WORDS = 1 << `MEM_ADDR_BITS;

	logic clk;
	logic rst_n;
	logic clear_req;
	// index 0 is the cpu port, 1 the i/o port
	sysbus_pkg::bus_req_t req [2];
	logic req_valid [2];
	logic req_ready [2];
	sysbus_pkg::bus_rsp_t rsp [2];
	logic rsp_valid [2];
	logic rsp_ready [2];

	// reference copy of block 0
	logic [15:0] ref_mem [0:MEM_WORDS-1];
	int errors = 0;
	int checks = 0;
	int cycle = 0;
	logic [31:0] seed = 32'd75;

	tb_clock u_clock (.clk(clk));

	sysbus_top u_dut (
		.clk_sys(clk), .rst_n(rst_n), .clear_req(clear_req),
		.cpu_req(req[0]), .cpu_req_valid(req_valid[0]), .cpu_req_ready(req_ready[0]),
		.cpu_rsp(rsp[0]), .cpu_rsp_valid(rsp_valid[0]), .cpu_rsp_ready(rsp_ready[0]),
		.io_req(req[1]), .io_req_valid(req_valid[1]), .io_req_ready(req_ready[1]),
		.io_rsp(rsp[1]), .io_rsp_valid(rsp_valid[1]), .io_rsp_ready(rsp_ready[1])
	);

	// free running cycle count for ordering checks
	always @(posedge clk) cycle <= cycle + 1;

	// ------------------------------
	// helpers
	// ------------------------------

	function automatic int lcg_next();
		seed = seed * 32'd1103515245 + 32'd12345;
		return int'(seed[30:16]);
	endfunction

	function automatic sysbus_pkg::bus_req_t make_req(logic write, logic [3:0] nb,
			logic [15:0] ad, logic [15:0] dt);
		sysbus_pkg::bus_req_t rq;
		rq.write = write;
		rq.nb = nb;
		rq.ad = ad;
		rq.dt = dt;
		return rq;
	endfunction

	// block 0 below the memory size answers, everything else is nomem
	function automatic sysbus_pkg::bus_rsp_t expect_rsp(sysbus_pkg::bus_req_t rq);
		sysbus_pkg::bus_rsp_t e;
		e.dt = 16'h0000;
		e.status = sysbus_pkg::RSP_NOMEM;
		if (rq.nb == 4'd0 && int'(rq.ad) < MEM_WORDS) begin
			e.status = sysbus_pkg::RSP_OK;
			if (!rq.write) e.dt = ref_mem[rq.ad[`MEM_ADDR_BITS-1:0]];
		end
		return e;
	endfunction

	// one request through a port, rsp_ready held low for hold cycles
	task automatic run_xfer(input int port, input string name, input sysbus_pkg::bus_req_t rq,
			input int hold, output int rsp_cycle);
		sysbus_pkg::bus_rsp_t exp;
		sysbus_pkg::bus_rsp_t first;
		int n;
		exp = expect_rsp(rq);
		rsp_cycle = -1;
		@(posedge clk);
		req[port] <= rq;
		req_valid[port] <= 1'b1;
		rsp_ready[port] <= (hold == 0);
		n = 0;
		@(negedge clk);
		while (!req_ready[port] && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!req_ready[port]) begin
			errors++;
			$display("%s: port %0d never became ready for a request", name, port);
			@(posedge clk);
			req_valid[port] <= 1'b0;
			return;
		end
		// handshake on this edge
		@(posedge clk);
		req_valid[port] <= 1'b0;
		n = 0;
		@(negedge clk);
		while (!rsp_valid[port] && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (!rsp_valid[port]) begin
			errors++;
			$display("%s: port %0d gave no response", name, port);
			return;
		end
		rsp_cycle = cycle;
		first = rsp[port];
		// back-pressure, response must sit still
		for (int i = 0; i < hold; i++) begin
			@(negedge clk);
			checks++;
			if (!rsp_valid[port] || rsp[port] !== first) begin
				errors++;
				$display("** Error %s: expected held %h, actual %h", name, first, rsp[port]);
			end
			checks++;
			if (req_ready[port] !== 1'b0) begin
				errors++;
				$display("** Error %s: expected req_ready 0, actual %b", name, req_ready[port]);
			end
		end
		if (hold > 0) begin
			@(posedge clk);
			rsp_ready[port] <= 1'b1;
		end
		@(posedge clk);
		rsp_ready[port] <= 1'b0;
		checks++;
		if (first !== exp) begin
			errors++;
			$display("** Error %s: expected %h, actual %h", name, exp, first);
		end
		if (rq.write && exp.status == sysbus_pkg::RSP_OK) begin
			ref_mem[rq.ad[`MEM_ADDR_BITS-1:0]] = rq.dt;
		end
	endtask

	task automatic xfer(input int port, input string name, input sysbus_pkg::bus_req_t rq);
		int unused_cycle;
		run_xfer(port, name, rq, 0, unused_cycle);
	endtask

	// req_ready goes low, stays low through the clear, then comes back
	task automatic measure_clear(input int port, input string name);
		int n;
		int low;
		n = 0;
		@(negedge clk);
		while (req_ready[port] && n < WAIT_LIMIT) begin
			@(negedge clk);
			n++;
		end
		if (req_ready[port]) begin
			errors++;
			$display("%s: req_ready on port %0d never went low", name, port);
			return;
		end
		low = 0;
		while (!req_ready[port] && low < WAIT_LIMIT) begin
			@(negedge clk);
			low++;
		end
		if (!req_ready[port]) begin
			errors++;
			$display("%s: req_ready on port %0d never came back", name, port);
			return;
		end
		checks++;
		if (low < `CLEAR_CYCLES) begin
			errors++;
			$display("** Error %s: expected >= %0d low cycles, actual %0d", name,
				`CLEAR_CYCLES, low);
		end
	endtask

	// ------------------------------
	// directed tests
	// ------------------------------

	task automatic write_read_back(input int port);
		logic [15:0] ad;
		ad = 16'h0010 + 16'(port);
		xfer(port, "write_read", make_req(1'b1, 4'd0, ad, 16'(lcg_next())));
		xfer(port, "write_read", make_req(1'b0, 4'd0, ad, 16'h0000));
	endtask

	task automatic no_memory_access();
		xfer(0, "no_memory", make_req(1'b1, 4'd0, 16'h0005, 16'h5a5a));
		xfer(0, "no_memory", make_req(1'b0, 4'd3, 16'h0005, 16'h0000));
		xfer(1, "no_memory", make_req(1'b0, 4'd0, 16'h0105, 16'h0000));
		// would alias word 5 if decode ignored the upper bits or nb
		xfer(0, "no_memory", make_req(1'b1, 4'd0, 16'h0105, 16'ha5a5));
		xfer(1, "no_memory", make_req(1'b1, 4'd1, 16'h0005, 16'hffff));
		xfer(0, "no_memory", make_req(1'b0, 4'd0, 16'h0005, 16'h0000));
	endtask

	task automatic port_arbitration();
		int cpu_cycle;
		int io_cycle;
		xfer(1, "arbitration", make_req(1'b1, 4'd0, 16'h0031, 16'h1357));
		fork
			run_xfer(0, "arbitration", make_req(1'b1, 4'd0, 16'h0030, 16'h2468), 0, cpu_cycle);
			run_xfer(1, "arbitration", make_req(1'b0, 4'd0, 16'h0031, 16'h0000), 0, io_cycle);
		join
		checks++;
		if (cpu_cycle < 0 || io_cycle < 0 || cpu_cycle >= io_cycle) begin
			errors++;
			$display("** Error arbitration: expected cpu response before cycle %0d, actual %0d",
				io_cycle, cpu_cycle);
		end
	endtask

	task automatic response_back_pressure();
		int hold;
		int unused_cycle;
		hold = 2 + lcg_next() % 6;
		run_xfer(1, "back_pressure", make_req(1'b0, 4'd0, 16'h0031, 16'h0000), hold,
			unused_cycle);
		xfer(1, "back_pressure", make_req(1'b0, 4'd0, 16'h0030, 16'h0000));
	endtask

	task automatic clear_keeps_memory();
		xfer(0, "clear", make_req(1'b1, 4'd0, 16'h0022, 16'hc0de));
		@(posedge clk);
		clear_req <= 1'b1;
		@(posedge clk);
		clear_req <= 1'b0;
		fork
			measure_clear(0, "clear");
			measure_clear(1, "clear");
		join
		// memory survives the clear
		xfer(1, "clear", make_req(1'b0, 4'd0, 16'h0022, 16'h0000));
	endtask

	// each port owns eight words, so the two can run side by side
	function automatic sysbus_pkg::bus_req_t random_req(int port);
		logic [15:0] ad;
		ad = 16'h0040 + 16'(port * 8) + 16'(lcg_next() % 8);
		return make_req(lcg_next() % 2 == 1, 4'd0, ad, 16'(lcg_next()));
	endfunction

	task automatic mixed_traffic();
		sysbus_pkg::bus_req_t rq0;
		sysbus_pkg::bus_req_t rq1;
		for (int i = 0; i < 8; i++) begin
			fork
				xfer(0, "mixed", make_req(1'b1, 4'd0, 16'h0040 + 16'(i), 16'(lcg_next())));
				xfer(1, "mixed", make_req(1'b1, 4'd0, 16'h0048 + 16'(i), 16'(lcg_next())));
			join
		end
		for (int i = 0; i < 12; i++) begin
			rq0 = random_req(0);
			rq1 = random_req(1);
			fork
				xfer(0, "mixed", rq0);
				xfer(1, "mixed", rq1);
			join
		end
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------

	initial begin
		rst_n <= 1'b0;
		clear_req <= 1'b0;
		for (int p = 0; p < 2; p++) begin
			req[p] <= '0;
			req_valid[p] <= 1'b0;
			rsp_ready[p] <= 1'b0;
		end
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		fork
			measure_clear(0, "reset_clear");
			measure_clear(1, "reset_clear");
		join
		write_read_back(0);
		write_read_back(1);
		no_memory_access();
		port_arbitration();
		response_back_pressure();
		clear_keeps_memory();
		mixed_traffic();
		repeat (2) @(posedge clk);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- verilog.f
+incdir+logic
logic/sysbus_pkg.sv
logic/bus_switch.sv
logic/bus_master.sv
logic/bus_memory.sv
logic/power_clear.sv
logic/sysbus_top.sv
verif/tb_clock.sv
verif/sysbus_properties.sv
verif/tb_sysbus.sv
